/* include/segway_consts.svh */
`ifndef SEGWAY_CONSTS_SVH
`define SEGWAY_CONSTS_SVH

// torque, effort and wheel speed width
`define SEG_TRQ_W 12

// steering pot clip window and centre point
`define SEG_STEER_MIN 12'h200
`define SEG_STEER_MAX 12'hE00
`define SEG_STEER_MID 12'h7FF

// motor dead zone compensation
`define SEG_MIN_DUTY 12'h0A8
`define SEG_LOW_BAND 12'h02A
`define SEG_LOW_GAIN 4

// wheel speed above which too_fast is raised
`define SEG_FAST_LIM 1536

// PD controller gains
`define SEG_P_COEFF 3
`define SEG_D_COEFF 8

`endif

/* rtl/segway_ctrl_pkg.sv */
`default_nettype none

`include "segway_consts.svh"

package segway_ctrl_pkg;

    // one rider sample as it arrives from the sensor side
    typedef struct packed {
        logic signed [`SEG_TRQ_W-1:0] ptch_err;
        logic        [`SEG_TRQ_W-1:0] steer_pot;
        logic                         en_steer;
        logic                         pwr_up;
    } rider_sample_t;

    // controller output with the steering fields passed through untouched
    typedef struct packed {
        logic signed [`SEG_TRQ_W-1:0] pid_cntrl;
        logic        [7:0]            ss_tmr;
        logic        [`SEG_TRQ_W-1:0] steer_pot;
        logic                         en_steer;
        logic                         pwr_up;
    } effort_t;

endpackage

`default_nettype wire

/* rtl/segway_drive_pkg.sv */
`default_nettype none

`include "segway_consts.svh"

package segway_drive_pkg;

    // final per-wheel speed command
    typedef struct packed {
        logic signed [`SEG_TRQ_W-1:0] lft_spd;
        logic signed [`SEG_TRQ_W-1:0] rght_spd;
        // either wheel above the speed limit
        logic                         too_fast;
    } wheel_cmd_t;

endpackage

`default_nettype wire

/* rtl/skid_buffer.sv */
`default_nettype none

module skid_buffer #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    // second entry catches a beat when the output stalls
    T     skid_data;
    logic skid_valid;
    logic in_xfer;
    logic main_free;

    // ready comes straight from a flop
    assign in_ready  = !skid_valid;
    assign in_xfer   = in_valid && in_ready;
    assign main_free = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // drain skid first so ordering holds
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_xfer;
            end
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_xfer) begin
                out_data <= in_data;
            end
        end else if (in_xfer) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/deadzone_shaper.sv */
`default_nettype none

`include "segway_consts.svh"

module deadzone_shaper (
    input  logic signed [`SEG_TRQ_W:0] torque_in,
    input  logic                       pwr_up,
    output logic signed [`SEG_TRQ_W:0] torque_shaped
);

    localparam logic signed [`SEG_TRQ_W:0] MIN_DUTY = `SEG_MIN_DUTY;
    localparam logic        [`SEG_TRQ_W:0] LOW_BAND = `SEG_LOW_BAND;
    localparam logic signed [`SEG_TRQ_W:0] LOW_GAIN = `SEG_LOW_GAIN;

    logic        [`SEG_TRQ_W:0] torque_mag;
    logic signed [`SEG_TRQ_W:0] torque_comp;
    logic signed [`SEG_TRQ_W:0] torque_low;

    assign torque_mag = torque_in[`SEG_TRQ_W] ? $unsigned(-torque_in) : $unsigned(torque_in);

    // push away from zero past the motor's stiction
    assign torque_comp = torque_in[`SEG_TRQ_W] ? torque_in - MIN_DUTY : torque_in + MIN_DUTY;

    // small torques get extra gain so the joint to the offset band is smooth
    assign torque_low = torque_in * LOW_GAIN;

    always_comb begin
        if (!pwr_up) begin
            torque_shaped = '0;
        end else if (torque_mag > LOW_BAND) begin
            torque_shaped = torque_comp;
        end else begin
            torque_shaped = torque_low;
        end
    end

endmodule

`default_nettype wire

/* rtl/balance_pd_ctrl.sv */
`default_nettype none

`include "segway_consts.svh"

module balance_pd_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  segway_ctrl_pkg::rider_sample_t  in_sample,
    input  logic                            in_valid,
    output logic                            in_ready,
    output segway_ctrl_pkg::effort_t        out_effort,
    output logic                            out_valid,
    input  logic                            out_ready
);

    // wide enough for 3*err + 8*(err - prev) without wrap
    localparam int PW = `SEG_TRQ_W + 6;

    localparam logic signed [PW-1:0] P_COEFF = `SEG_P_COEFF;
    localparam logic signed [PW-1:0] D_COEFF = `SEG_D_COEFF;
    localparam logic signed [`SEG_TRQ_W-1:0] EFF_MAX = {1'b0, {(`SEG_TRQ_W-1){1'b1}}};
    localparam logic signed [`SEG_TRQ_W-1:0] EFF_MIN = {1'b1, {(`SEG_TRQ_W-1){1'b0}}};
    localparam logic [7:0] TMR_MAX = 8'hFF;

    logic signed [`SEG_TRQ_W-1:0] prev_err;
    logic        [7:0]            ss_tmr;
    logic signed [`SEG_TRQ_W:0]   err_diff;
    logic signed [PW-1:0]         p_term;
    logic signed [PW-1:0]         d_term;
    logic signed [PW-1:0]         effort_sum;
    logic signed [`SEG_TRQ_W-1:0] effort_sat;
    logic                         accept;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // derivative against the last accepted error
    assign err_diff = $signed({in_sample.ptch_err[`SEG_TRQ_W-1], in_sample.ptch_err})
                    - $signed({prev_err[`SEG_TRQ_W-1], prev_err});

    assign p_term     = $signed(in_sample.ptch_err) * P_COEFF;
    assign d_term     = err_diff * D_COEFF;
    assign effort_sum = p_term + d_term;

    always_comb begin
        if (effort_sum > EFF_MAX) begin
            effort_sat = EFF_MAX;
        end else if (effort_sum < EFF_MIN) begin
            effort_sat = EFF_MIN;
        end else begin
            effort_sat = effort_sum[`SEG_TRQ_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            prev_err  <= '0;
            ss_tmr    <= '0;
        end else if (accept) begin
            out_valid <= 1'b1;
            prev_err  <= in_sample.ptch_err;
            // ramp restarts whenever power drops
            if (!in_sample.pwr_up) begin
                ss_tmr <= '0;
            end else if (ss_tmr != TMR_MAX) begin
                ss_tmr <= ss_tmr + 8'd1;
            end
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // effort carries the timer before this sample bumps it
    always_ff @(posedge clk) begin
        if (accept) begin
            out_effort.pid_cntrl <= effort_sat;
            out_effort.ss_tmr    <= ss_tmr;
            out_effort.steer_pot <= in_sample.steer_pot;
            out_effort.en_steer  <= in_sample.en_steer;
            out_effort.pwr_up    <= in_sample.pwr_up;
        end
    end

endmodule

`default_nettype wire

/* rtl/segway_math.sv */
`default_nettype none

`include "segway_consts.svh"

module segway_math (
    input  logic                          clk,
    input  logic                          rst_n,
    input  segway_ctrl_pkg::effort_t      in_effort,
    input  logic                          in_valid,
    output logic                          in_ready,
    output segway_drive_pkg::wheel_cmd_t  out_cmd,
    output logic                          out_valid,
    input  logic                          out_ready
);

    localparam logic [`SEG_TRQ_W-1:0] STEER_MIN = `SEG_STEER_MIN;
    localparam logic [`SEG_TRQ_W-1:0] STEER_MAX = `SEG_STEER_MAX;
    localparam logic [`SEG_TRQ_W-1:0] STEER_MID = `SEG_STEER_MID;
    localparam logic signed [`SEG_TRQ_W-1:0] FAST_LIM = `SEG_FAST_LIM;

    // clamps a 13-bit torque to a 12-bit speed on overflow
    function automatic logic signed [`SEG_TRQ_W-1:0] sat_trq(
        input logic signed [`SEG_TRQ_W:0] t
    );
        logic signed [`SEG_TRQ_W-1:0] r;
        if (t[`SEG_TRQ_W] == t[`SEG_TRQ_W-1]) begin
            r = t[`SEG_TRQ_W-1:0];
        end else if (t[`SEG_TRQ_W]) begin
            r = {1'b1, {(`SEG_TRQ_W-1){1'b0}}};
        end else begin
            r = {1'b0, {(`SEG_TRQ_W-1){1'b1}}};
        end
        return r;
    endfunction

    logic signed [`SEG_TRQ_W+8:0] ss_prod;
    logic signed [`SEG_TRQ_W-1:0] pid_ss;
    logic        [`SEG_TRQ_W-1:0] steer_clip;
    logic signed [`SEG_TRQ_W-1:0] steer_off;
    logic signed [`SEG_TRQ_W-1:0] steer_scaled;

    logic                         s1_valid;
    logic signed [`SEG_TRQ_W-1:0] s1_pid_ss;
    logic signed [`SEG_TRQ_W-1:0] s1_steer;
    logic                         s1_en_steer;
    logic                         s1_pwr_up;

    logic signed [`SEG_TRQ_W:0]   pid_ext;
    logic signed [`SEG_TRQ_W:0]   steer_ext;
    logic signed [`SEG_TRQ_W:0]   lft_trq;
    logic signed [`SEG_TRQ_W:0]   rght_trq;

    logic                         s2_valid;
    logic signed [`SEG_TRQ_W:0]   s2_lft_trq;
    logic signed [`SEG_TRQ_W:0]   s2_rght_trq;
    logic                         s2_pwr_up;

    logic signed [`SEG_TRQ_W:0]   lft_shaped;
    logic signed [`SEG_TRQ_W:0]   rght_shaped;
    logic signed [`SEG_TRQ_W-1:0] lft_spd;
    logic signed [`SEG_TRQ_W-1:0] rght_spd;
    logic                         s1_adv;
    logic                         s2_adv;

    // soft start scales the effort by tmr / 256
    assign ss_prod = $signed({1'b0, in_effort.ss_tmr}) * $signed(in_effort.pid_cntrl);
    assign pid_ss  = ss_prod[`SEG_TRQ_W+7:8];

    // clip pot to its window and centre it
    assign steer_clip = (in_effort.steer_pot < STEER_MIN) ? STEER_MIN :
                        (in_effort.steer_pot > STEER_MAX) ? STEER_MAX :
                        in_effort.steer_pot;
    assign steer_off  = $signed(steer_clip - STEER_MID);
    // 3/16 as 1/8 + 1/16
    assign steer_scaled = (steer_off >>> 3) + (steer_off >>> 4);

    // stage two mix with offsets of opposite sign per wheel
    assign pid_ext   = s1_pid_ss;
    assign steer_ext = s1_steer;
    assign lft_trq   = s1_en_steer ? pid_ext + steer_ext : pid_ext;
    assign rght_trq  = s1_en_steer ? pid_ext - steer_ext : pid_ext;

    assign s2_adv   = !s2_valid || out_ready;
    assign s1_adv   = !s1_valid || s2_adv;
    assign in_ready = s1_adv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= in_valid;
            end
            if (s2_adv) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv && in_valid) begin
            s1_pid_ss   <= pid_ss;
            s1_steer    <= steer_scaled;
            s1_en_steer <= in_effort.en_steer;
            s1_pwr_up   <= in_effort.pwr_up;
        end
        if (s2_adv && s1_valid) begin
            s2_lft_trq  <= lft_trq;
            s2_rght_trq <= rght_trq;
            s2_pwr_up   <= s1_pwr_up;
        end
    end

    deadzone_shaper i_dz_lft (
        .torque_in     (s2_lft_trq),
        .pwr_up        (s2_pwr_up),
        .torque_shaped (lft_shaped)
    );

    deadzone_shaper i_dz_rght (
        .torque_in     (s2_rght_trq),
        .pwr_up        (s2_pwr_up),
        .torque_shaped (rght_shaped)
    );

    assign lft_spd  = sat_trq(lft_shaped);
    assign rght_spd = sat_trq(rght_shaped);

    assign out_valid        = s2_valid;
    assign out_cmd.lft_spd  = lft_spd;
    assign out_cmd.rght_spd = rght_spd;
    assign out_cmd.too_fast = (lft_spd > FAST_LIM) || (rght_spd > FAST_LIM);

endmodule

`default_nettype wire

/* rtl/segway_drive_top.sv */
`default_nettype none

module segway_drive_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  segway_ctrl_pkg::rider_sample_t sample,
    input  logic                          sample_valid,
    output logic                          sample_ready,
    output segway_drive_pkg::wheel_cmd_t  cmd,
    output logic                          cmd_valid,
    input  logic                          cmd_ready
);

    segway_ctrl_pkg::rider_sample_t buf_sample;
    logic                           buf_valid;
    logic                           pd_ready;

    segway_ctrl_pkg::effort_t       effort;
    logic                           effort_valid;
    logic                           math_ready;

    segway_drive_pkg::wheel_cmd_t   math_cmd;
    logic                           math_valid;
    logic                           out_buf_ready;

    skid_buffer #(.T(segway_ctrl_pkg::rider_sample_t)) i_in_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (sample),
        .in_valid  (sample_valid),
        .in_ready  (sample_ready),
        .out_data  (buf_sample),
        .out_valid (buf_valid),
        .out_ready (pd_ready)
    );

    balance_pd_ctrl i_pd (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_sample  (buf_sample),
        .in_valid   (buf_valid),
        .in_ready   (pd_ready),
        .out_effort (effort),
        .out_valid  (effort_valid),
        .out_ready  (math_ready)
    );

    segway_math i_math (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_effort (effort),
        .in_valid  (effort_valid),
        .in_ready  (math_ready),
        .out_cmd   (math_cmd),
        .out_valid (math_valid),
        .out_ready (out_buf_ready)
    );

    skid_buffer #(.T(segway_drive_pkg::wheel_cmd_t)) i_out_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (math_cmd),
        .in_valid  (math_valid),
        .in_ready  (out_buf_ready),
        .out_data  (cmd),
        .out_valid (cmd_valid),
        .out_ready (cmd_ready)
    );

endmodule

`default_nettype wire

/* sim/segway_props.sv */
`default_nettype none

module segway_props (
    input logic                           clk,
    input logic                           rst_n,
    input segway_ctrl_pkg::rider_sample_t sample,
    input logic                           sample_valid,
    input logic                           sample_ready,
    input segway_drive_pkg::wheel_cmd_t   cmd,
    input logic                           cmd_valid,
    input logic                           cmd_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // output idle and input open right after reset
    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !cmd_valid && sample_ready)
        else $error("cmd_valid high or sample_ready low when reset was released");

    // a stalled command must not change
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("cmd or cmd_valid changed while the output was stalled");

    // same rule for the rider sample side
    a_sample_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample))
        else $error("sample or sample_valid changed while the input was stalled");

endmodule

bind segway_drive_top segway_props i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready)
);

`default_nettype wire

/* sim/segway_tb.sv */
`default_nettype none

module segway_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_SMP  = 1024;
    localparam int MAX_TST  = 16;
    localparam int WAIT_LIM = 200;

    logic                           clk;
    logic                           rst_n;
    segway_ctrl_pkg::rider_sample_t sample;
    logic                           sample_valid;
    logic                           sample_ready;
    segway_drive_pkg::wheel_cmd_t   cmd;
    logic                           cmd_valid;
    logic                           cmd_ready;

    // case file contents with one entry per sample
    segway_ctrl_pkg::rider_sample_t smp_q [MAX_SMP];
    segway_drive_pkg::wheel_cmd_t   exp_q [MAX_SMP];
    logic                           chk_q [MAX_SMP];
    logic [8*24-1:0]                tst_name [MAX_TST];
    logic                           tst_bp [MAX_TST];
    int                             tst_first [MAX_TST];
    int                             tst_cnt [MAX_TST];

    int          n_smp;
    int          n_tst;
    int          errors;
    int          checks;
    int          cycle_cnt = 0;
    int          accept_at;
    logic        timed_out;
    logic [31:0] rnd;

    segway_drive_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_field(input string name, input logic [11:0] got,
                                 input logic [11:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("Error at %0t: %0s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_cases();
        int              fd;
        string           line;
        int              a;
        int              b;
        int              c;
        int              d;
        int              e;
        int              f;
        int              g;
        logic [8*24-1:0] nm;
        fd = $fopen("sim/segway_cases.txt", "r");
        n_smp = 0;
        n_tst = 0;
        if (fd == 0) begin
            $display("could not open the case file sim/segway_cases.txt");
            timed_out = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0) begin
                    continue;
                end
                if (line[0] == "t") begin
                    void'($sscanf(line, "test %s %d", nm, a));
                    tst_name[n_tst]  = nm;
                    tst_bp[n_tst]    = a[0];
                    tst_first[n_tst] = n_smp;
                    tst_cnt[n_tst]   = 0;
                    n_tst++;
                end else if (line[0] == "s") begin
                    void'($sscanf(line, "s %h %h %d %d %h %h %d", a, b, c, d, e, f, g));
                    smp_q[n_smp] = '{ptch_err: a[11:0], steer_pot: b[11:0],
                                     en_steer: c[0], pwr_up: d[0]};
                    exp_q[n_smp] = '{lft_spd: e[11:0], rght_spd: f[11:0], too_fast: g[0]};
                    chk_q[n_smp] = 1'b1;
                    tst_cnt[n_tst-1]++;
                    n_smp++;
                end else if (line[0] == "p") begin
                    // warm-up run expands into e unchecked samples
                    void'($sscanf(line, "p %h %h %d %d %d", a, b, c, d, e));
                    for (int i = 0; i < e; i++) begin
                        smp_q[n_smp] = '{ptch_err: a[11:0], steer_pot: b[11:0],
                                         en_steer: c[0], pwr_up: d[0]};
                        exp_q[n_smp] = '0;
                        chk_q[n_smp] = 1'b0;
                        tst_cnt[n_tst-1]++;
                        n_smp++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        cmd_ready    = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
    endtask

    task automatic drive_samples(input int t);
        int tmo;
        for (int i = 0; i < tst_cnt[t] && !timed_out; i++) begin
            sample       = smp_q[tst_first[t] + i];
            sample_valid = 1'b1;
            tmo          = 0;
            while (!sample_ready && !timed_out) begin
                @(negedge clk);
                tmo++;
                if (tmo > WAIT_LIM) begin
                    $display("sample_ready stayed low for %0d cycles at %0t", WAIT_LIM, $time);
                    timed_out = 1'b1;
                end
            end
            if (i == 0) begin
                accept_at = cycle_cnt;
            end
            @(negedge clk);
        end
        sample_valid = 1'b0;
    endtask

    task automatic collect_results(input int t);
        int   got;
        int   idle;
        int   first_seen;
        int   idx;
        logic seen;
        got  = 0;
        idle = 0;
        seen = 1'b0;
        while (got < tst_cnt[t] && !timed_out) begin
            @(negedge clk);
            rnd       = xorshift32(rnd);
            cmd_ready = tst_bp[t] ? rnd[0] : 1'b1;
            if (cmd_valid && !seen) begin
                seen       = 1'b1;
                first_seen = cycle_cnt;
            end
            if (cmd_valid && cmd_ready) begin
                idx = tst_first[t] + got;
                if (chk_q[idx]) begin
                    compare_field("cmd.lft_spd", cmd.lft_spd, exp_q[idx].lft_spd);
                    compare_field("cmd.rght_spd", cmd.rght_spd, exp_q[idx].rght_spd);
                    compare_field("cmd.too_fast", {11'b0, cmd.too_fast},
                                  {11'b0, exp_q[idx].too_fast});
                end
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIM) begin
                    $display("no command after %0d cycles, %0d results missing at %0t",
                             WAIT_LIM, tst_cnt[t] - got, $time);
                    timed_out = 1'b1;
                end
            end
        end
        if (!tst_bp[t] && seen) begin
            assert (first_seen - accept_at == 5) else begin
                $display("Error at %0t: cmd_valid latency got %0d expected 5",
                         $time, first_seen - accept_at);
                errors++;
            end
        end
        cmd_ready = 1'b1;
    endtask

    // nothing extra may come out after the last expected result
    task automatic check_drained();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (!cmd_valid) else begin
                $display("Error at %0t: cmd_valid got 1 expected 0", $time);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before = errors;
        apply_reset();
        fork
            drive_samples(t);
            collect_results(t);
        join
        if (!timed_out) begin
            check_drained();
        end
        $display("test %0s: %0d samples, %0d errors%0s", tst_name[t], tst_cnt[t],
                 errors - errs_before, timed_out ? ", timed out" : "");
    endtask

    initial begin
        rst_n        = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        cmd_ready    = 1'b0;
        errors       = 0;
        checks       = 0;
        accept_at    = 0;
        timed_out    = 1'b0;
        rnd          = 32'h394a;
        load_cases();
        for (int t = 0; t < n_tst && !timed_out; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", n_tst, checks, errors);
        if (errors == 0 && !timed_out && n_tst > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
rtl/segway_ctrl_pkg.sv
rtl/segway_drive_pkg.sv
rtl/skid_buffer.sv
rtl/deadzone_shaper.sv
rtl/balance_pd_ctrl.sv
rtl/segway_math.sv
rtl/segway_drive_top.sv
sim/segway_props.sv
sim/segway_tb.sv

/* Makefile */
# Verilator build and run of the drive datapath testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module segway_tb \
		-f sources.f -o segway_sim
	./obj_dir/segway_sim | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/segway_cases.txt */
# test <name> <backpressure 0|1>
# s <ptch_err> <steer_pot> <en_steer> <pwr_up> <lft_spd> <rght_spd> <too_fast>, hex, 12 bit
# p <ptch_err> <steer_pot> <en_steer> <pwr_up> <count>, warm-up samples with unchecked results
test power_off 0
s 2AB 7FF 0 1 000 000 0
s 2AB 7FF 0 1 01C 01C 0
s 2AB F00 1 0 000 000 0
s 2AB 7FF 0 1 000 000 0
test soft_start 0
s 2AB 7FF 0 1 000 000 0
s 2AB 7FF 0 1 01C 01C 0
s 2AB 7FF 0 1 03C 03C 0
s 2AB 7FF 0 1 05C 05C 0
s 2AB 7FF 0 1 07C 07C 0
s 2AB 7FF 0 1 09C 09C 0
s 2AB 7FF 0 1 0D7 0D7 0
test steering 0
s 000 100 1 1 E38 1C8 0
s 000 7FF 1 1 000 000 0
s 000 900 1 1 0D8 F28 0
s 000 F00 1 1 1C8 E38 0
s 000 F00 0 1 000 000 0
test dead_zone 0
s 000 830 1 1 024 FDC 0
s 000 8DF 1 1 0A8 F58 0
s 000 8E7 1 1 0D3 F2D 0
test saturation 0
p 2AB 7FF 0 1 260
s 2AB F00 1 1 7FF 77F 1
s 2AB 7FF 1 1 7FF 7FF 1
s 800 100 1 1 800 880 0
s 800 7FF 0 1 800 800 0
s 1D0 7FF 0 1 7FF 7FF 1
s 1D0 F00 1 1 732 4F2 1
test backpressure 1
p 2AB 7FF 0 1 260
s 2AB F00 1 1 7FF 77F 1
s 2AB 7FF 1 1 7FF 7FF 1
s 800 100 1 1 800 880 0
s 800 7FF 0 1 800 800 0
s 1D0 7FF 0 1 7FF 7FF 1
s 1D0 F00 1 1 732 4F2 1
